//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= memAccessCtrlTb
FILELIST   ?= memAccessCtrl.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/bankRouter.sv
/*
 * Bank router
 * Decodes the popped request and writes a bank queue and the in-order buffer
 */
`timescale 1ns/1ps

module bankRouter (
  input  logic                          clk,
  input  logic                          resetn,
  input  macPkg::reqT                   reqWr,
  input  macPkg::reqT                   reqRd,
  input  logic                          validWr,
  input  logic                          validRd,
  output logic [macPkg::NumBanks-1:0]   bankWr,
  output macPkg::bankReqT               bankItem,
  output logic                          orderWr,
  output macPkg::bankT                  orderBank
);

  macPkg::reqT  sel;
  macPkg::bankT selBank;
  logic         selValid;

  // Arbiter never pops both, so at most one side is valid
  assign selValid = validWr || validRd;
  assign sel      = validWr ? reqWr : reqRd;
  assign selBank  = sel.addr[macPkg::BankLsb +: macPkg::BankW];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      bankWr  <= '0;
      orderWr <= 1'b0;
    end else begin
      bankWr <= '0;
      if (selValid) bankWr[selBank] <= 1'b1;  // One-hot strobe
      orderWr <= selValid;
    end
  end

  always_ff @(posedge clk) begin
    if (selValid) begin
      bankItem.row    <= sel.addr[macPkg::RowLsb +: macPkg::RowW];
      bankItem.col    <= sel.addr[macPkg::ColLsb +: macPkg::ColW];
      bankItem.tag    <= sel.tag;
      bankItem.id     <= sel.id;
      bankItem.isLoad <= validRd;  // Came from the read queue
      orderBank       <= selBank;
    end
  end

endmodule

//--- hw/issueSequencer.sv
/*
 * Issue sequencer
 * Walks the in-order buffer, pops the named bank queue and issues with row-hit
 */
`timescale 1ns/1ps

module issueSequencer (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          orderEmpty,
  input  macPkg::bankT                  orderBank,
  input  logic                          orderValid,
  output logic                          orderRd,
  output logic [macPkg::NumBanks-1:0]   bankRd,
  input  macPkg::bankReqT               bankItem [macPkg::NumBanks],
  output logic                          issueValid,
  output macPkg::bankT                  issueBank,
  output macPkg::rowT                   issueRow,
  output macPkg::colT                   issueCol,
  output macPkg::tagT                   issueTag,
  output macPkg::idT                    issueId,
  output logic                          issueLoad,
  output logic                          issueRowHit
);

  typedef enum logic {Idle, Fetch} stateT;

  stateT                       state;
  logic                        headValid;  // Order rdata holds an unserved entry
  logic                        headAvail;
  logic                        take;
  macPkg::bankT                fetchBank;
  macPkg::bankReqT             item;
  macPkg::rowT                 openRow [macPkg::NumBanks];
  logic [macPkg::NumBanks-1:0] openValid;

  assign headAvail = headValid || orderValid;
  assign take      = (state == Idle) && headAvail;
  assign item      = bankItem[fetchBank];

  // Next order entry is fetched alongside the bank pop, or primes an empty head
  assign orderRd = (state == Idle) && !orderEmpty;

  always_comb begin
    bankRd = '0;
    if (take) bankRd[orderBank] = 1'b1;
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state      <= Idle;
      headValid  <= 1'b0;
      issueValid <= 1'b0;
      openValid  <= '0;
    end else begin
      headValid  <= headAvail && !take;
      issueValid <= (state == Fetch);
      case (state)
        Idle: begin
          if (take) state <= Fetch;
        end
        Fetch: begin
          openValid[fetchBank] <= 1'b1;
          state <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) fetchBank <= orderBank;
    if (state == Fetch) begin
      issueBank   <= fetchBank;
      issueRow    <= item.row;
      issueCol    <= item.col;
      issueTag    <= item.tag;
      issueId     <= item.id;
      issueLoad   <= item.isLoad;
      issueRowHit <= openValid[fetchBank] && (openRow[fetchBank] == item.row);
      openRow[fetchBank] <= item.row;  // Row stays open after access
    end
  end

endmodule

//--- hw/macPkg.sv
/*
 * Memory access controller package
 * Address map, field widths and the request payload types
 */
package macPkg;

  // Request fields
  localparam int AddrW = 32;
  localparam int TagW  = 4;
  localparam int IdW   = 3;

  // SDRAM address fields, bank interleaved above the column
  localparam int RowW  = 11;
  localparam int BankW = 2;
  localparam int ColW  = 8;

  localparam int RowLsb  = 19;  // Row is addr[29:19]
  localparam int BankLsb = 8;   // Bank is addr[9:8]
  localparam int ColLsb  = 0;   // Column is addr[7:0]

  localparam int NumBanks = 4;

  typedef logic [AddrW-1:0] addrT;
  typedef logic [TagW-1:0]  tagT;
  typedef logic [IdW-1:0]   idT;
  typedef logic [RowW-1:0]  rowT;
  typedef logic [BankW-1:0] bankT;
  typedef logic [ColW-1:0]  colT;

  // Channel queue entry, 39 bits
  typedef struct packed {
    addrT addr;
    tagT  tag;
    idT   id;
  } reqT;

  // Bank queue entry, 27 bits
  typedef struct packed {
    rowT  row;
    colT  col;
    tagT  tag;
    idT   id;
    logic isLoad;  // 1 for a read
  } bankReqT;

endpackage

//--- hw/memAccessCtrl.sv
/*
 * Memory access controller request front end
 * Channel queues, arbiter, bank router, bank queues and in-order issue
 */
`timescale 1ns/1ps

module memAccessCtrl #(
  parameter int ReqDepthLog2  = 5,
  parameter int BankDepthLog2 = 7,
  parameter int AlmostFullGap = 4
) (
  input  logic          clk,
  input  logic          resetn,
  input  logic          validWr,
  input  macPkg::addrT  addrWr,
  input  macPkg::tagT   tagWr,
  input  macPkg::idT    idWr,
  output logic          readyWr,
  input  logic          validRd,
  input  macPkg::addrT  addrRd,
  input  macPkg::tagT   tagRd,
  input  macPkg::idT    idRd,
  output logic          readyRd,
  output logic          issueValid,
  output macPkg::bankT  issueBank,
  output macPkg::rowT   issueRow,
  output macPkg::colT   issueCol,
  output macPkg::tagT   issueTag,
  output macPkg::idT    issueId,
  output logic          issueLoad,
  output logic          issueRowHit
);

  macPkg::reqT                 reqInWr;
  macPkg::reqT                 reqInRd;
  macPkg::reqT                 reqOutWr;
  macPkg::reqT                 reqOutRd;
  logic                        fullWr;
  logic                        fullRd;
  logic                        emptyWr;
  logic                        emptyRd;
  logic                        popWr;
  logic                        popRd;
  logic                        reqValidWr;
  logic                        reqValidRd;
  logic [macPkg::NumBanks-1:0] bankWr;
  logic [macPkg::NumBanks-1:0] bankRd;
  logic [macPkg::NumBanks-1:0] bankFull;   // Watched by the bound checks
  logic [macPkg::NumBanks-1:0] bankEmpty;
  macPkg::bankReqT             bankItemIn;
  macPkg::bankReqT             bankRdata [macPkg::NumBanks];
  logic                        orderWr;
  logic                        orderRd;
  logic                        orderValid;
  logic                        orderAlmostFull;
  logic                        orderEmpty;
  macPkg::bankT                orderBankIn;
  macPkg::bankT                orderBankOut;

  assign reqInWr = '{addr: addrWr, tag: tagWr, id: idWr};
  assign reqInRd = '{addr: addrRd, tag: tagRd, id: idRd};
  assign readyWr = !fullWr;
  assign readyRd = !fullRd;

  syncFifo #(
    .DepthLog2(ReqDepthLog2), .AlmostFullGap(AlmostFullGap), .ItemT(macPkg::reqT)
  ) u_queueWrReq (
    .clk(clk), .resetn(resetn), .wr(validWr), .wdata(reqInWr), .rd(popWr),
    .rdata(reqOutWr), .rdataValid(reqValidWr), .full(fullWr), .almostFull(),
    .empty(emptyWr)
  );

  syncFifo #(
    .DepthLog2(ReqDepthLog2), .AlmostFullGap(AlmostFullGap), .ItemT(macPkg::reqT)
  ) u_queueRdReq (
    .clk(clk), .resetn(resetn), .wr(validRd), .wdata(reqInRd), .rd(popRd),
    .rdata(reqOutRd), .rdataValid(reqValidRd), .full(fullRd), .almostFull(),
    .empty(emptyRd)
  );

  rwArbiter u_arbiter (
    .clk(clk), .resetn(resetn), .emptyWr(emptyWr), .emptyRd(emptyRd),
    .stall(orderAlmostFull), .popWr(popWr), .popRd(popRd)
  );

  bankRouter u_router (
    .clk(clk), .resetn(resetn), .reqWr(reqOutWr), .reqRd(reqOutRd),
    .validWr(reqValidWr), .validRd(reqValidRd), .bankWr(bankWr),
    .bankItem(bankItemIn), .orderWr(orderWr), .orderBank(orderBankIn)
  );

  for (genvar b = 0; b < macPkg::NumBanks; b++) begin : u_bankQueue
    syncFifo #(
      .DepthLog2(BankDepthLog2), .AlmostFullGap(AlmostFullGap), .ItemT(macPkg::bankReqT)
    ) u_fifo (
      .clk(clk), .resetn(resetn), .wr(bankWr[b]), .wdata(bankItemIn), .rd(bankRd[b]),
      .rdata(bankRdata[b]), .rdataValid(), .full(bankFull[b]), .almostFull(),
      .empty(bankEmpty[b])
    );
  end

  syncFifo #(
    .DepthLog2(BankDepthLog2), .AlmostFullGap(AlmostFullGap), .ItemT(macPkg::bankT)
  ) u_orderBuf (
    .clk(clk), .resetn(resetn), .wr(orderWr), .wdata(orderBankIn), .rd(orderRd),
    .rdata(orderBankOut), .rdataValid(orderValid), .full(),
    .almostFull(orderAlmostFull), .empty(orderEmpty)
  );

  issueSequencer u_sequencer (
    .clk(clk), .resetn(resetn), .orderEmpty(orderEmpty), .orderBank(orderBankOut),
    .orderValid(orderValid), .orderRd(orderRd), .bankRd(bankRd), .bankItem(bankRdata),
    .issueValid(issueValid), .issueBank(issueBank), .issueRow(issueRow),
    .issueCol(issueCol), .issueTag(issueTag), .issueId(issueId),
    .issueLoad(issueLoad), .issueRowHit(issueRowHit)
  );

endmodule

//--- hw/rwArbiter.sv
/*
 * Round-robin arbiter between the write and read request queues
 * Pops at most one queue per cycle, held off by downstream stall
 */
`timescale 1ns/1ps

module rwArbiter (
  input  logic clk,
  input  logic resetn,
  input  logic emptyWr,
  input  logic emptyRd,
  input  logic stall,
  output logic popWr,
  output logic popRd
);

  logic lastWr;  // Write side won the last grant
  logic bothReady;

  assign bothReady = !emptyWr && !emptyRd;

  always_comb begin
    popWr = 1'b0;
    popRd = 1'b0;
    if (!stall) begin
      if (bothReady) begin
        // Alternate when both sides wait
        popWr = !lastWr;
        popRd = lastWr;
      end else begin
        popWr = !emptyWr;
        popRd = !emptyRd;
      end
    end
  end

  // Read counts as last winner out of reset, so write goes first
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      lastWr <= 1'b0;
    end else if (popWr || popRd) begin
      lastWr <= popWr;
    end
  end

endmodule

//--- hw/syncFifo.sv
/*
 * Synchronous FIFO with a registered read port
 * Full, almost-full and empty flags; payload type set by parameter
 */
`timescale 1ns/1ps

module syncFifo #(
  parameter int  DepthLog2     = 4,
  parameter int  AlmostFullGap = 2,
  parameter type ItemT         = logic [7:0]
) (
  input  logic clk,
  input  logic resetn,
  input  logic wr,
  input  ItemT wdata,
  input  logic rd,
  output ItemT rdata,
  output logic rdataValid,
  output logic full,
  output logic almostFull,
  output logic empty
);

  localparam int Depth = 2 ** DepthLog2;

  ItemT                 mem [Depth];
  logic [DepthLog2-1:0] wrPtr;
  logic [DepthLog2-1:0] rdPtr;
  logic [DepthLog2:0]   count;
  logic                 doWr;
  logic                 doRd;

  assign doWr = wr && !full;   // Write on full is dropped
  assign doRd = rd && !empty;

  assign full       = (count == (DepthLog2+1)'(Depth));
  assign almostFull = (count >= (DepthLog2+1)'(Depth - AlmostFullGap));
  assign empty      = (count == '0);

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      rdataValid <= 1'b0;
    end else begin
      rdataValid <= doRd;
      if (doWr) wrPtr <= wrPtr + 1'b1;
      if (doRd) rdPtr <= rdPtr + 1'b1;
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read register, rdata holds until the next read
  always_ff @(posedge clk) begin
    if (doWr) mem[wrPtr] <= wdata;
    if (doRd) rdata <= mem[rdPtr];
  end

endmodule

//--- memAccessCtrl.f
hw/macPkg.sv
hw/syncFifo.sv
hw/rwArbiter.sv
hw/bankRouter.sv
hw/issueSequencer.sv
hw/memAccessCtrl.sv
verif/memAccessCtrl_asserts.sv
verif/memAccessCtrlTb.sv

//--- verif/memAccessCtrlTb.sv
/*
 * Testbench for the memory access controller front end
 * Drives both request channels and checks every issue against a reference model
 */
`timescale 1ns/1ps

module memAccessCtrlTb;

  localparam int ClkHalfNs   = 2;
  localparam int TestCycles  = 2000;  // Issue-bound length of all six tests
  localparam int WatchdogNs  = TestCycles * 2 * ClkHalfNs * 5 / 2;
  localparam int DrainCycles = 1000;  // Well above two cycles per queued request

  typedef struct packed {
    macPkg::bankReqT item;
    macPkg::bankT    bank;
  } expectT;

  logic            clk;
  logic            resetn;
  logic            validWr;
  macPkg::addrT    addrWr;
  macPkg::tagT     tagWr;
  macPkg::idT      idWr;
  logic            readyWr;
  logic            validRd;
  macPkg::addrT    addrRd;
  macPkg::tagT     tagRd;
  macPkg::idT      idRd;
  logic            readyRd;
  logic            issueValid;
  macPkg::bankT    issueBank;
  macPkg::rowT     issueRow;
  macPkg::colT     issueCol;
  macPkg::tagT     issueTag;
  macPkg::idT      issueId;
  logic            issueLoad;
  logic            issueRowHit;

  expectT                      expWr [$];
  expectT                      expRd [$];
  macPkg::rowT                 openRowRef [macPkg::NumBanks];
  logic [macPkg::NumBanks-1:0] openValidRef;
  logic [31:0]                 lcgState;
  string                       testName;
  logic                        alternate;  // Fixed write/read order expected
  logic                        nextLoad;
  logic                        sawWrStall;
  int                          acceptCount;
  int                          issueCount;

  memAccessCtrl u_dut (
    .clk(clk), .resetn(resetn),
    .validWr(validWr), .addrWr(addrWr), .tagWr(tagWr), .idWr(idWr), .readyWr(readyWr),
    .validRd(validRd), .addrRd(addrRd), .tagRd(tagRd), .idRd(idRd), .readyRd(readyRd),
    .issueValid(issueValid), .issueBank(issueBank), .issueRow(issueRow),
    .issueCol(issueCol), .issueTag(issueTag), .issueId(issueId),
    .issueLoad(issueLoad), .issueRowHit(issueRowHit)
  );

  always #(ClkHalfNs) clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Two rows in banks 0 and 1 so rows repeat often
  function automatic macPkg::addrT hotAddr();
    logic [31:0] r;
    logic [10:0] row;
    r   = nextRand();
    row = r[21] ? 11'h155 : 11'h2aa;
    return {2'b00, row, 9'h000, 1'b0, r[23], r[31:24]};
  endfunction

  // Expected issue from the address map (row 29..19, bank 9..8, column 7..0)
  function automatic expectT expectIssue(input macPkg::addrT addr, input macPkg::tagT tag,
                                         input macPkg::idT id, input logic isLoad);
    expectT e;
    e.item.row    = addr[29:19];
    e.item.col    = addr[7:0];
    e.item.tag    = tag;
    e.item.id     = id;
    e.item.isLoad = isLoad;
    e.bank        = addr[9:8];
    return e;
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkItem(input macPkg::bankReqT want, input macPkg::bankReqT got);
    if (got !== want)
      abortRun($sformatf("Error: test %s, issued item expected %h actual %h",
                         testName, want, got));
  endtask

  task automatic checkBank(input macPkg::bankT want, input macPkg::bankT got);
    if (got !== want)
      abortRun($sformatf("Error: test %s, issue bank expected %0d actual %0d",
                         testName, want, got));
  endtask

  task automatic checkHit(input logic want, input logic got);
    if (got !== want)
      abortRun($sformatf("Error: test %s, row hit expected %b actual %b", testName, want, got));
  endtask

  task automatic checkCount(input int want, input int got);
    if (got != want)
      abortRun($sformatf("Error: test %s, issue count expected %0d actual %0d",
                         testName, want, got));
  endtask

  task automatic driveWr(input macPkg::addrT addr);
    logic [31:0] r;
    r = nextRand();
    validWr <= 1'b1;
    addrWr  <= addr;
    tagWr   <= r[27:24];
    idWr    <= r[30:28];
  endtask

  task automatic driveRd(input macPkg::addrT addr);
    logic [31:0] r;
    r = nextRand();
    validRd <= 1'b1;
    addrRd  <= addr;
    tagRd   <= r[27:24];
    idRd    <= r[30:28];
  endtask

  // With perCycle set, stalled cycles count toward n as well
  task automatic writeStream(input int n, input logic hot, input logic perCycle);
    int done;
    done = 0;
    while (done < n) begin
      @(posedge clk);
      if (readyWr) begin
        driveWr(hot ? hotAddr() : nextRand());
        done++;
      end else begin
        validWr <= 1'b0;
        if (perCycle) done++;
      end
    end
    @(posedge clk);
    validWr <= 1'b0;
  endtask

  task automatic readStream(input int n);
    int done;
    done = 0;
    while (done < n) begin
      @(posedge clk);
      if (readyRd) begin
        driveRd(nextRand());
        done++;
      end else begin
        validRd <= 1'b0;
      end
    end
    @(posedge clk);
    validRd <= 1'b0;
  endtask

  task automatic mixedStream(input int cycles, input logic both);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      r = nextRand();
      if (readyWr && (both || r[31])) driveWr(nextRand());
      else validWr <= 1'b0;
      if (readyRd && (both || r[30])) driveRd(nextRand());
      else validRd <= 1'b0;
    end
    @(posedge clk);
    validWr <= 1'b0;
    validRd <= 1'b0;
  endtask

  // Leftovers after the drain limit are caught by the later checks
  task automatic waitDrain();
    int waited;
    waited = 0;
    @(posedge clk);
    while ((expWr.size() != 0 || expRd.size() != 0) && waited < DrainCycles) begin
      @(posedge clk);
      waited++;
    end
    repeat (4) @(posedge clk);
  endtask

  // Acceptance monitor sees the values from before the edge
  always @(posedge clk) begin
    if (resetn) begin
      if (validWr && readyWr) begin
        expWr.push_back(expectIssue(addrWr, tagWr, idWr, 1'b0));
        acceptCount++;
      end
      if (validRd && readyRd) begin
        expRd.push_back(expectIssue(addrRd, tagRd, idRd, 1'b1));
        acceptCount++;
      end
      if (!readyWr) sawWrStall = 1'b1;
    end
  end

  always @(posedge clk) begin
    expectT          want;
    macPkg::bankReqT got;
    logic            useLoad;
    logic            hitWant;
    if (resetn && issueValid) begin
      useLoad = alternate ? nextLoad : issueLoad;
      if (useLoad) begin
        if (expRd.size() == 0) abortRun("A read was issued with no outstanding read request");
        want = expRd.pop_front();
      end else begin
        if (expWr.size() == 0) abortRun("A write was issued with no outstanding write request");
        want = expWr.pop_front();
      end
      got = '{row: issueRow, col: issueCol, tag: issueTag, id: issueId, isLoad: issueLoad};
      checkItem(want.item, got);
      checkBank(want.bank, issueBank);
      hitWant = openValidRef[want.bank] && (openRowRef[want.bank] == want.item.row);
      checkHit(hitWant, issueRowHit);
      openValidRef[want.bank] = 1'b1;
      openRowRef[want.bank]   = want.item.row;
      nextLoad = !nextLoad;
      issueCount++;
    end
  end

  initial begin
    #(WatchdogNs);
    abortRun("Timeout: the tests did not finish within the watchdog time");
  end

  initial begin
    clk = 1'b0;
    resetn = 1'b0;
    validWr = 1'b0;
    addrWr = '0;
    tagWr = '0;
    idWr = '0;
    validRd = 1'b0;
    addrRd = '0;
    tagRd = '0;
    idRd = '0;
    lcgState = 32'h3bff;
    openValidRef = '0;
    alternate = 1'b0;
    nextLoad = 1'b0;
    sawWrStall = 1'b0;
    acceptCount = 0;
    issueCount = 0;
    testName = "reset";
    repeat (16) @(posedge clk);
    resetn <= 1'b1;
    repeat (4) @(posedge clk);
    if (readyWr !== 1'b1 || readyRd !== 1'b1)
      abortRun($sformatf("Error: test %s, ready flags expected 11 actual %b%b",
                         testName, readyWr, readyRd));

    testName = "writeOnly";
    writeStream(32, 1'b0, 1'b0);
    waitDrain();

    testName = "readOnly";
    readStream(32);
    waitDrain();

    testName = "simultaneous";
    nextLoad  = 1'b0;  // Write goes first
    alternate = 1'b1;
    mixedStream(16, 1'b1);
    waitDrain();
    alternate = 1'b0;

    testName = "rowHits";
    writeStream(24, 1'b1, 1'b0);
    waitDrain();

    testName = "backPressure";
    acceptCount = 0;
    issueCount  = 0;
    sawWrStall  = 1'b0;
    writeStream(400, 1'b0, 1'b1);
    waitDrain();
    if (!sawWrStall) abortRun("readyWr never went low during the back-pressure test");
    checkCount(acceptCount, issueCount);

    testName = "randomMixed";
    mixedStream(300, 1'b0);
    waitDrain();

    if (expWr.size() != 0 || expRd.size() != 0) begin
      abortRun("Accepted requests were left without an issue");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- verif/memAccessCtrl_asserts.sv
/*
 * Bound checks on queue pops, bank queue writes and the issue strobe
 */
`timescale 1ns/1ps

module memAccessCtrl_asserts (
  input logic                        clk,
  input logic                        resetn,
  input logic                        popWr,
  input logic                        popRd,
  input logic                        emptyWr,
  input logic                        emptyRd,
  input logic [macPkg::NumBanks-1:0] bankWr,
  input logic [macPkg::NumBanks-1:0] bankFull,
  input logic [macPkg::NumBanks-1:0] bankRd,
  input logic [macPkg::NumBanks-1:0] bankEmpty,
  input logic                        issueValid
);

  popOneHot: assert property (@(posedge clk) disable iff (!resetn) !(popWr && popRd))
    else $error("Both request queues popped in the same cycle");

  popNotEmpty: assert property (@(posedge clk) disable iff (!resetn)
    !(popWr && emptyWr) && !(popRd && emptyRd) && ((bankRd & bankEmpty) == '0))
    else $error("A queue was popped while empty");

  bankNoOverflow: assert property (@(posedge clk) disable iff (!resetn)
    (bankWr & bankFull) == '0)
    else $error("A bank queue was written while full");

  issueSingle: assert property (@(posedge clk) disable iff (!resetn) issueValid |=> !issueValid)
    else $error("issueValid was high two cycles running");

endmodule

bind memAccessCtrl memAccessCtrl_asserts u_asserts (
  .clk(clk), .resetn(resetn), .popWr(popWr), .popRd(popRd),
  .emptyWr(emptyWr), .emptyRd(emptyRd), .bankWr(bankWr), .bankFull(bankFull),
  .bankRd(bankRd), .bankEmpty(bankEmpty), .issueValid(issueValid)
);
